/* logic/sonar_pkg.sv */
`default_nettype none

package sonar_pkg;

  localparam int WINDOW_LEN  = 8;    // steps per energy window
  localparam int MAX_DELAY   = 255;  // listening limit per attempt, in steps
  localparam int BURST_LEN   = 4;    // speaker burst length, in steps
  localparam int MAX_RETRIES = 2;    // repeat attempts before timeout
  localparam int DELAY_W     = 8;
  localparam int SUM_W       = 12;   // 8 magnitudes of at most 128

  localparam logic signed [15:0] BURST_AMP = 16'sd12000;

  // derived counter widths
  localparam int BURST_CNT_W = $clog2(BURST_LEN + 1);
  localparam int WIN_IDX_W   = $clog2(WINDOW_LEN);
  localparam int RETRY_W     = $clog2(MAX_RETRIES + 1);

  typedef enum logic [1:0] {
    IDLE,
    PLAYING,
    LISTENING,
    DONE
  } ranger_state_e;

  typedef struct packed {
    logic [SUM_W-1:0] cur;        // window just completed
    logic [SUM_W-1:0] prev;
    logic [SUM_W-1:0] prev_prev;
  } window_sums_t;

  typedef struct packed {
    logic [DELAY_W-1:0] delay;    // steps from burst end to onset window start
    logic               valid;
    logic               timed_out;
  } range_result_t;

endpackage

`default_nettype wire

/* logic/impulse_generator.sv */
`timescale 1ns/1ps
`default_nettype none

module impulse_generator (
  input  wire                 clk_in,
  input  wire                 rst_in,
  input  wire                 step_in,
  input  wire                 start,
  output logic signed [15:0]  amp_out,
  output logic                done
);

  logic [sonar_pkg::BURST_CNT_W-1:0] count;  // burst steps still to play
  logic                              phase;  // 1 plays the negative half

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      count   <= '0;
      phase   <= 1'b0;
      amp_out <= 16'sd0;
      done    <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start) begin
        // a step arriving with start already plays the first sample
        count   <= step_in ? sonar_pkg::BURST_CNT_W'(sonar_pkg::BURST_LEN - 1)
                           : sonar_pkg::BURST_CNT_W'(sonar_pkg::BURST_LEN);
        phase   <= step_in;
        amp_out <= step_in ? sonar_pkg::BURST_AMP : 16'sd0;
      end else if (step_in) begin
        if (count != '0) begin
          amp_out <= phase ? -sonar_pkg::BURST_AMP : sonar_pkg::BURST_AMP;
          phase   <= ~phase;
          count   <= count - 1'b1;
          done    <= (count == sonar_pkg::BURST_CNT_W'(1));  // last burst step
        end else begin
          amp_out <= 16'sd0;  // silent between bursts
        end
      end
    end
  end

endmodule

`default_nettype wire

/* logic/window_energy.sv */
`timescale 1ns/1ps
`default_nettype none

module window_energy (
  input  wire                     clk_in,
  input  wire                     rst_in,
  input  wire                     step_in,
  input  wire                     listen,
  input  wire                     clear,
  input  wire signed [7:0]        mic_in,
  output logic                    window_end,
  output sonar_pkg::window_sums_t sums
);

  logic [sonar_pkg::SUM_W-1:0]     acc;       // running sum of the open window
  logic [sonar_pkg::WIN_IDX_W-1:0] idx;       // position inside the window
  logic [8:0]                      mag;       // -128 maps to 128
  logic [sonar_pkg::SUM_W-1:0]     acc_base;
  logic [sonar_pkg::WIN_IDX_W-1:0] idx_base;
  sonar_pkg::window_sums_t         sums_base;

  assign mag = mic_in[7] ? (9'd256 - {1'b0, mic_in}) : {1'b0, mic_in};

  // clear restarts everything, even when a step lands in the same cycle
  assign acc_base  = clear ? '0 : acc;
  assign idx_base  = clear ? '0 : idx;
  assign sums_base = clear ? '0 : sums;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      acc        <= '0;
      idx        <= '0;
      sums       <= '0;
      window_end <= 1'b0;
    end else begin
      window_end <= 1'b0;
      if (listen && step_in) begin
        if (idx_base == sonar_pkg::WIN_IDX_W'(sonar_pkg::WINDOW_LEN - 1)) begin
          // publish and age the history
          sums.cur       <= acc_base + sonar_pkg::SUM_W'(mag);
          sums.prev      <= sums_base.cur;
          sums.prev_prev <= sums_base.prev;
          acc            <= '0;
          idx            <= '0;
          window_end     <= 1'b1;
        end else begin
          sums <= sums_base;
          acc  <= acc_base + sonar_pkg::SUM_W'(mag);
          idx  <= idx_base + 1'b1;
        end
      end else if (clear) begin
        sums <= '0;
        acc  <= '0;
        idx  <= '0;
      end
    end
  end

endmodule

`default_nettype wire

/* logic/onset_detector.sv */
`timescale 1ns/1ps
`default_nettype none

module onset_detector (
  input  wire                          window_end,
  input  wire sonar_pkg::window_sums_t sums,
  output logic                         onset
);

  logic [sonar_pkg::SUM_W:0] threshold;  // oldest window times 1.5 needs one extra bit
  logic                      above_prev;
  logic                      above_thresh;

  assign threshold = {1'b0, sums.prev_prev} + {2'b00, sums.prev_prev[sonar_pkg::SUM_W-1:1]};

  assign above_prev   = sums.cur > sums.prev;
  assign above_thresh = {1'b0, sums.cur} > threshold;

  // an all-zero history makes the first nonzero window an onset
  assign onset = window_end && above_prev && above_thresh;

endmodule

`default_nettype wire

/* logic/echo_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module echo_controller (
  input  wire                      clk_in,
  input  wire                      rst_in,
  input  wire                      step_in,
  input  wire                      trigger,
  input  wire                      burst_done,
  input  wire                      window_end,
  input  wire                      onset,
  output logic                     start,
  output logic                     listen,
  output logic                     clear,
  output sonar_pkg::range_result_t result
);

  sonar_pkg::ranger_state_e          state;
  logic [sonar_pkg::DELAY_W-1:0]     step_cnt;      // listening steps this attempt
  logic [sonar_pkg::DELAY_W-1:0]     window_start;  // first step of the open window
  logic [sonar_pkg::RETRY_W-1:0]     retry_cnt;

  assign listen = (state == sonar_pkg::LISTENING);

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state        <= sonar_pkg::IDLE;
      step_cnt     <= '0;
      window_start <= '0;
      retry_cnt    <= '0;
      start        <= 1'b0;
      clear        <= 1'b0;
      result       <= '0;
    end else begin
      start <= 1'b0;
      clear <= 1'b0;
      case (state)
        sonar_pkg::IDLE, sonar_pkg::DONE: begin
          if (trigger) begin
            result.valid     <= 1'b0;
            result.timed_out <= 1'b0;
            retry_cnt        <= '0;
            start            <= 1'b1;
            state            <= sonar_pkg::PLAYING;
          end
        end

        sonar_pkg::PLAYING: begin
          if (burst_done) begin
            clear        <= 1'b1;  // fresh history for this attempt
            step_cnt     <= '0;
            window_start <= '0;
            state        <= sonar_pkg::LISTENING;
          end
        end

        sonar_pkg::LISTENING: begin
          if (window_end && onset) begin
            result.delay <= window_start;
            result.valid <= 1'b1;
            state        <= sonar_pkg::DONE;
          end else if (step_cnt == sonar_pkg::DELAY_W'(sonar_pkg::MAX_DELAY)) begin
            if (retry_cnt == sonar_pkg::RETRY_W'(sonar_pkg::MAX_RETRIES)) begin
              result.timed_out <= 1'b1;  // all attempts used
              state            <= sonar_pkg::DONE;
            end else begin
              retry_cnt <= retry_cnt + 1'b1;
              start     <= 1'b1;
              state     <= sonar_pkg::PLAYING;
            end
          end else begin
            if (step_in) begin
              step_cnt <= step_cnt + 1'b1;
            end
            if (window_end) begin
              window_start <= window_start + sonar_pkg::DELAY_W'(sonar_pkg::WINDOW_LEN);
            end
          end
        end

        default: state <= sonar_pkg::IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

/* logic/sonar_ranger.sv */
`timescale 1ns/1ps
`default_nettype none

module sonar_ranger (
  input  wire                      clk_in,
  input  wire                      rst_in,
  input  wire                      step_in,
  input  wire                      trigger,
  input  wire signed [7:0]         mic_in,
  output logic signed [15:0]       amp_out,
  output sonar_pkg::range_result_t result
);

  logic                    start;
  logic                    burst_done;
  logic                    listen;
  logic                    clear;
  logic                    window_end;
  logic                    onset;
  sonar_pkg::window_sums_t sums;

  // speaker side
  impulse_generator impulse_generator_inst (
    .clk_in  (clk_in),
    .rst_in  (rst_in),
    .step_in (step_in),
    .start   (start),
    .amp_out (amp_out),
    .done    (burst_done)
  );

  // microphone side
  window_energy window_energy_inst (
    .clk_in     (clk_in),
    .rst_in     (rst_in),
    .step_in    (step_in),
    .listen     (listen),
    .clear      (clear),
    .mic_in     (mic_in),
    .window_end (window_end),
    .sums       (sums)
  );

  onset_detector onset_detector_inst (
    .window_end (window_end),
    .sums       (sums),
    .onset      (onset)
  );

  echo_controller echo_controller_inst (
    .clk_in     (clk_in),
    .rst_in     (rst_in),
    .step_in    (step_in),
    .trigger    (trigger),
    .burst_done (burst_done),
    .window_end (window_end),
    .onset      (onset),
    .start      (start),
    .listen     (listen),
    .clear      (clear),
    .result     (result)
  );

endmodule

`default_nettype wire

/* dv/sonar_ranger_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module sonar_ranger_tb;

  localparam int STEP_LIMIT = 4000;    // steps allowed per measurement
  localparam int ECHO_LEN   = 12;      // echo burst length in steps
  localparam int FAR_IDX    = 100000;  // no burst seen yet
  localparam int STRAY_STEP = 20;      // stray trigger while measuring

  logic                     clk_in;
  logic                     rst_in;
  logic                     step_in;
  logic                     trigger;
  logic signed [7:0]        mic_in;
  logic signed [15:0]       amp_out;
  sonar_pkg::range_result_t result;

  logic [31:0] lfsr_state;
  int          listen_idx;   // listening step that the next step lands on
  int          last_idx;     // listening step of the most recent step
  int          burst_cnt;    // samples of the burst in progress
  int          bursts_seen;
  int          echo_off;
  int          echo_amp;
  int          noise_amp;
  int          exp_delay;
  int          exp_timeout;

  sonar_ranger sonar_ranger_inst (
    .clk_in  (clk_in),
    .rst_in  (rst_in),
    .step_in (step_in),
    .trigger (trigger),
    .mic_in  (mic_in),
    .amp_out (amp_out),
    .result  (result)
  );

  always #2 clk_in = ~clk_in;

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("TB FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    lfsr_step = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // n bits, lsb first, one lfsr step per bit
  function automatic int take_bits(input int n);
    int v;
    int i;
    v = 0;
    for (i = 0; i < n; i++) begin
      v = v | (int'(lfsr_state[0]) << i);
      lfsr_state = lfsr_step(lfsr_state);
    end
    return v;
  endfunction

  // uniform in -amp..amp by rejection
  function automatic int draw_noise(input int amp);
    int span;
    int width;
    int v;
    int tries;
    if (amp == 0) return 0;
    span  = 2 * amp + 1;
    width = $clog2(span);
    v     = span;
    tries = 0;
    while (v >= span && tries < 64) begin
      v = take_bits(width);
      tries++;
    end
    if (v >= span) v = amp;
    return v - amp;
  endfunction

  function automatic logic signed [7:0] mic_sample(input int idx);
    int s;
    s = draw_noise(noise_amp);
    if (echo_amp != 0 && idx >= echo_off && idx < echo_off + ECHO_LEN) begin
      s = s + (((idx - echo_off) % 2 == 0) ? echo_amp : -echo_amp);  // alternating echo
    end
    if (s > 127) s = 127;
    if (s < -128) s = -128;
    return 8'(s);
  endfunction

  // speaker model: a nonzero sample marks a burst step
  task automatic check_burst();
    logic signed [15:0] want;
    if (amp_out != 16'sd0) begin
      want = (burst_cnt % 2 == 0) ? sonar_pkg::BURST_AMP : -sonar_pkg::BURST_AMP;
      assert (burst_cnt < sonar_pkg::BURST_LEN && amp_out == want)
        else abort_run($sformatf("mismatch at %0t: burst sample %0d is %0d, expected %0d",
                                 $time, burst_cnt, amp_out, want));
      burst_cnt++;
      listen_idx = 0;  // listening starts with the next step
    end else begin
      if (burst_cnt != 0) begin
        assert (burst_cnt == sonar_pkg::BURST_LEN)
          else abort_run($sformatf("mismatch at %0t: burst had %0d samples, expected %0d",
                                   $time, burst_cnt, sonar_pkg::BURST_LEN));
        bursts_seen++;
        burst_cnt = 0;
      end
      listen_idx++;
    end
  endtask

  // one step period of four clocks, trigger in the second one
  task automatic do_step(input logic trig);
    @(negedge clk_in);
    step_in  = 1'b1;
    mic_in   = mic_sample(listen_idx);
    last_idx = listen_idx;
    @(negedge clk_in);
    step_in = 1'b0;
    trigger = trig;
    check_burst();
    @(negedge clk_in);
    trigger = 1'b0;
    @(negedge clk_in);
  endtask

  task automatic run_measurement();
    int                       steps;
    sonar_pkg::range_result_t held;
    listen_idx  = FAR_IDX;
    bursts_seen = 0;
    do_step(1'b1);
    assert (!result.valid && !result.timed_out)
      else abort_run($sformatf("mismatch at %0t: trigger left valid %0b timed_out %0b",
                               $time, result.valid, result.timed_out));
    steps = 0;
    while (!result.valid && !result.timed_out && steps < STEP_LIMIT) begin
      do_step(steps == STRAY_STEP);  // must be ignored while busy
      steps++;
    end
    assert (steps < STEP_LIMIT)
      else abort_run($sformatf("timeout, no result within %0d steps of the trigger",
                               STEP_LIMIT));
    assert (result.timed_out == (exp_timeout != 0) && result.valid == (exp_timeout == 0))
      else abort_run($sformatf("mismatch at %0t: valid %0b timed_out %0b for offset %0d",
                               $time, result.valid, result.timed_out, echo_off));
    if (exp_timeout == 0) begin
      assert (result.delay == sonar_pkg::DELAY_W'(exp_delay))
        else abort_run($sformatf("mismatch at %0t: delay %0d, expected %0d",
                                 $time, result.delay, exp_delay));
      // valid follows the last step of the onset window
      assert (last_idx == exp_delay + sonar_pkg::WINDOW_LEN - 1)
        else abort_run($sformatf("mismatch at %0t: valid after step %0d, expected %0d",
                                 $time, last_idx, exp_delay + sonar_pkg::WINDOW_LEN - 1));
      assert (bursts_seen == 1)
        else abort_run($sformatf("mismatch at %0t: %0d bursts, expected 1",
                                 $time, bursts_seen));
    end else begin
      assert (bursts_seen == sonar_pkg::MAX_RETRIES + 1)
        else abort_run($sformatf("mismatch at %0t: %0d bursts, expected %0d",
                                 $time, bursts_seen, sonar_pkg::MAX_RETRIES + 1));
    end
    held = result;
    repeat (3) do_step(1'b0);
    assert (result == held)
      else abort_run($sformatf("mismatch at %0t: result changed while waiting in DONE", $time));
  endtask

  initial begin
    int    fd;
    int    n;
    int    fields;
    int    line_no;
    int    measured;
    string line;
    clk_in      = 1'b0;
    rst_in      = 1'b1;
    step_in     = 1'b0;
    trigger     = 1'b0;
    mic_in      = 8'sd0;
    lfsr_state  = 32'hf8a9c390;
    listen_idx  = FAR_IDX;
    last_idx    = 0;
    burst_cnt   = 0;
    bursts_seen = 0;
    echo_off    = 0;
    echo_amp    = 0;
    noise_amp   = 0;
    exp_delay   = 0;
    exp_timeout = 0;
    repeat (2) @(posedge clk_in);
    @(negedge clk_in);
    rst_in = 1'b0;
    assert (amp_out == 16'sd0 && !result.valid && !result.timed_out)
      else abort_run($sformatf("mismatch at %0t: outputs not idle after reset", $time));

    fd = $fopen("dv/ranger_patterns.txt", "r");
    assert (fd != 0) else abort_run("could not open dv/ranger_patterns.txt");
    line_no  = 0;
    measured = 0;
    while (!$feof(fd)) begin
      line = "";
      n    = $fgets(line, fd);
      line_no++;
      if (n == 0 || line.len() < 2 || line.getc(0) == "#") continue;  // comments, blanks
      fields = $sscanf(line, "%d %d %d %d %d",
                       echo_off, echo_amp, noise_amp, exp_delay, exp_timeout);
      assert (fields == 5)
        else abort_run($sformatf("pattern line %0d does not hold five numbers", line_no));
      run_measurement();
      measured++;
    end
    $fclose(fd);
    assert (measured > 0) else abort_run("the pattern file held no measurements");
    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
logic/sonar_pkg.sv
logic/impulse_generator.sv
logic/window_energy.sv
logic/onset_detector.sv
logic/echo_controller.sv
logic/sonar_ranger.sv
dv/sonar_ranger_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the sonar_ranger testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f flist.f --top-module sonar_ranger_tb -o sim_sonar_ranger
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_sonar_ranger > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "TB FAILED" "$LOG"; then
  echo "simulation reported a failure"
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "simulator exited with status $status"
  exit 1
fi

echo "simulation finished without failures"
exit 0

/* dv/ranger_patterns.txt */
# echo_offset echo_amplitude noise_amplitude expected_delay expected_timeout
# offsets and delays in listening steps after the last burst step, amplitude 0 means no echo
40 100 0 40 0
45 100 0 40 0
0 60 0 0 0
7 20 0 0 0
8 20 0 8 0
# noise makes window 0 nonzero, and the first nonzero window counts as the onset
64 100 2 0 0
30 90 3 0 0
# silent room, three attempts and then timeout
0 0 0 0 1
100 1 0 96 0
127 127 0 120 0
240 80 0 240 0
247 80 0 240 0
# window 31 never completes before the listening limit
248 80 0 0 1
24 50 0 24 0
55 70 0 48 0
